/* logic/conv_sum_pkg.sv */
// widths, latencies, kernel mode enum and packed structs for the convolution summing unit

package conv_sum_pkg;

    // word widths
    localparam int FEATURE_WIDTH = 16;
    localparam int SCALER_WIDTH  = 16;
    localparam int CHANNEL_WIDTH = 5;

    // window geometry
    localparam int WINDOW_TAPS  = 25;
    localparam int KERNEL3_TAPS = 9;

    // pipeline depths in clk cycles
    localparam int TREE_LATENCY = 4;
    localparam int POST_LATENCY = 2;

    typedef enum logic {
        KN_MODE_5X5 = 1'b0,
        KN_MODE_3X3 = 1'b1
    } kernel_mode_e;

    typedef logic [FEATURE_WIDTH-1:0] feature_t;

    // tap 0 sits in the lowest bits
    typedef logic [WINDOW_TAPS-1:0][FEATURE_WIDTH-1:0] window_taps_t;

    // one window of products entering the unit
    typedef struct packed {
        logic                     valid;
        kernel_mode_e             mode;
        logic [CHANNEL_WIDTH-1:0] channel;
        window_taps_t             taps;
    } window_req_t;

    // tree result handed from producer to consumer
    typedef struct packed {
        logic                     valid;
        kernel_mode_e             mode;
        logic [CHANNEL_WIDTH-1:0] channel;
        feature_t                 sum_even;
        feature_t                 sum_odd;
    } kernel_sum_t;

    // quasi-static post-processing values
    typedef struct packed {
        logic [SCALER_WIDTH-1:0] scaler;
        feature_t                bias;
    } post_params_t;

    // final scaled and biased output
    typedef struct packed {
        logic                     valid;
        logic [CHANNEL_WIDTH-1:0] channel;
        feature_t                 result_even;
        feature_t                 result_odd;
    } conv_result_t;

endpackage

/* logic/kernel_adder_tree.sv */
// kernel_adder_tree: four-layer registered tree giving the 5x5 sum and two 3x3 sums
`timescale 1ns/100ps

module kernel_adder_tree (
    input  logic                       clk,
    input  logic                       rst,
    input  conv_sum_pkg::window_taps_t i_taps,
    output conv_sum_pkg::feature_t     o_sum5,
    output conv_sum_pkg::feature_t     o_sum3_even,
    output conv_sum_pkg::feature_t     o_sum3_odd
);
    import conv_sum_pkg::*;

    // first of the seven taps outside both 3x3 kernels
    localparam int REST_BASE = 2 * KERNEL3_TAPS;

    // layer 0, per kernel two quads and one single tap
    logic [1:0][1:0][FEATURE_WIDTH-1:0] quad_q;
    logic [1:0][FEATURE_WIDTH-1:0]      single_q;
    // layer 0, leftover taps in pairs, last one alone
    logic [3:0][FEATURE_WIDTH-1:0]      pair_q;

    // layer 1
    logic [1:0][FEATURE_WIDTH-1:0]      kern_q;
    feature_t                           rest_q;

    // layer 2
    feature_t                           sum5_q;
    logic [1:0][FEATURE_WIDTH-1:0]      kern_d_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            quad_q   <= '0;
            single_q <= '0;
            pair_q   <= '0;
        end else begin
            // kernel k covers taps k*9 .. k*9+8
            for (int k = 0; k < 2; k++) begin
                quad_q[k][0] <= i_taps[k*KERNEL3_TAPS] + i_taps[k*KERNEL3_TAPS+1]
                              + i_taps[k*KERNEL3_TAPS+2] + i_taps[k*KERNEL3_TAPS+3];
                quad_q[k][1] <= i_taps[k*KERNEL3_TAPS+4] + i_taps[k*KERNEL3_TAPS+5]
                              + i_taps[k*KERNEL3_TAPS+6] + i_taps[k*KERNEL3_TAPS+7];
                single_q[k]  <= i_taps[k*KERNEL3_TAPS+8];
            end
            for (int p = 0; p < 3; p++) begin
                pair_q[p] <= i_taps[REST_BASE+2*p] + i_taps[REST_BASE+2*p+1];
            end
            pair_q[3] <= i_taps[WINDOW_TAPS-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            kern_q <= '0;
            rest_q <= '0;
        end else begin
            for (int k = 0; k < 2; k++) begin
                kern_q[k] <= quad_q[k][0] + quad_q[k][1] + single_q[k];
            end
            rest_q <= pair_q[0] + pair_q[1] + pair_q[2] + pair_q[3];
        end
    end

    // 5x5 total built here, 3x3 sums only delayed to stay aligned
    always_ff @(posedge clk) begin
        if (rst) begin
            sum5_q   <= '0;
            kern_d_q <= '0;
        end else begin
            sum5_q   <= kern_q[0] + kern_q[1] + rest_q;
            kern_d_q <= kern_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_sum5      <= '0;
            o_sum3_even <= '0;
            o_sum3_odd  <= '0;
        end else begin
            o_sum5      <= sum5_q;
            o_sum3_even <= kern_d_q[0];
            o_sum3_odd  <= kern_d_q[1];
        end
    end

endmodule

/* logic/kernel_sum_stage.sv */
// kernel_sum_stage: adder tree with aligned valid, mode and channel, output select by mode
`timescale 1ns/100ps

module kernel_sum_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  conv_sum_pkg::window_req_t i_window,
    output conv_sum_pkg::kernel_sum_t o_sum
);
    import conv_sum_pkg::*;

    // sideband that rides alongside the tree
    typedef struct packed {
        logic                     valid;
        kernel_mode_e             mode;
        logic [CHANNEL_WIDTH-1:0] channel;
    } window_tag_t;

    window_tag_t [TREE_LATENCY-1:0] tag_q;
    window_tag_t                    tag_out;
    feature_t                       sum5;
    feature_t                       sum3_even;
    feature_t                       sum3_odd;

    // tree runs every cycle, valid only qualifies the result
    kernel_adder_tree u_tree (
        .clk         (clk),
        .rst         (rst),
        .i_taps      (i_window.taps),
        .o_sum5      (sum5),
        .o_sum3_even (sum3_even),
        .o_sum3_odd  (sum3_odd)
    );

    // one slot per tree layer, so several windows can be in flight
    always_ff @(posedge clk) begin
        if (rst) begin
            tag_q <= '0;
        end else begin
            tag_q[0] <= '{
                valid:   i_window.valid,
                mode:    i_window.mode,
                channel: i_window.channel
            };
            for (int s = 1; s < TREE_LATENCY; s++) begin
                tag_q[s] <= tag_q[s-1];
            end
        end
    end

    assign tag_out = tag_q[TREE_LATENCY-1];

    always_comb begin
        o_sum.valid   = tag_out.valid;
        o_sum.mode    = tag_out.mode;
        o_sum.channel = tag_out.channel;
        if (tag_out.mode == KN_MODE_3X3) begin
            o_sum.sum_even = sum3_even;
            o_sum.sum_odd  = sum3_odd;
        end else begin
            // single 5x5 kernel, odd lane unused
            o_sum.sum_even = sum5;
            o_sum.sum_odd  = '0;
        end
    end

endmodule

/* logic/scale_bias_stage.sv */
// scale_bias_stage: scaler multiply then bias add on both sums, channel tag carried along
`timescale 1ns/100ps

module scale_bias_stage (
    input  logic                       clk,
    input  logic                       rst,
    input  conv_sum_pkg::kernel_sum_t  i_sum,
    input  conv_sum_pkg::post_params_t i_post,
    output conv_sum_pkg::conv_result_t o_result
);
    import conv_sum_pkg::*;

    logic [POST_LATENCY-1:0]                    valid_q;
    logic [POST_LATENCY-1:0][CHANNEL_WIDTH-1:0] chan_q;
    kernel_mode_e                               mul_mode_q;
    feature_t                                   mul_even_q;
    feature_t                                   mul_odd_q;
    feature_t                                   res_even_q;
    feature_t                                   res_odd_q;

    // valid and channel shift through both stages
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            chan_q  <= '0;
        end else begin
            valid_q <= {valid_q[POST_LATENCY-2:0], i_sum.valid};
            chan_q  <= {chan_q[POST_LATENCY-2:0], i_sum.channel};
        end
    end

    // stage 1, product keeps its low FEATURE_WIDTH bits
    always_ff @(posedge clk) begin
        if (rst) begin
            mul_mode_q <= KN_MODE_5X5;
            mul_even_q <= '0;
            mul_odd_q  <= '0;
        end else begin
            mul_mode_q <= i_sum.mode;
            mul_even_q <= i_sum.sum_even * i_post.scaler;
            mul_odd_q  <= i_sum.sum_odd * i_post.scaler;
        end
    end

    // stage 2, bias add wraps mod 2^16
    always_ff @(posedge clk) begin
        if (rst) begin
            res_even_q <= '0;
            res_odd_q  <= '0;
        end else begin
            res_even_q <= mul_even_q + i_post.bias;
            // odd lane only carries a kernel in 3x3 mode
            if (mul_mode_q == KN_MODE_3X3) begin
                res_odd_q <= mul_odd_q + i_post.bias;
            end else begin
                res_odd_q <= '0;
            end
        end
    end

    assign o_result = '{
        valid:       valid_q[POST_LATENCY-1],
        channel:     chan_q[POST_LATENCY-1],
        result_even: res_even_q,
        result_odd:  res_odd_q
    };

endmodule

/* logic/conv_sum_top.sv */
// conv_sum_top: kernel summing producer feeding the scale and bias consumer
`timescale 1ns/100ps

module conv_sum_top (
    input  logic                       clk,
    input  logic                       rst,
    input  conv_sum_pkg::window_req_t  i_window,
    input  conv_sum_pkg::post_params_t i_post,
    output conv_sum_pkg::conv_result_t o_result
);
    import conv_sum_pkg::*;

    kernel_sum_t kernel_sum;

    kernel_sum_stage u_kernel_sum (
        .clk      (clk),
        .rst      (rst),
        .i_window (i_window),
        .o_sum    (kernel_sum)
    );

    // scaler and bias only change while the pipeline is empty
    scale_bias_stage u_scale_bias (
        .clk      (clk),
        .rst      (rst),
        .i_sum    (kernel_sum),
        .i_post   (i_post),
        .o_result (o_result)
    );

endmodule

/* verification/conv_sum_sva.sv */
// conv_sum_sva: bound checks on result valid timing, reset behavior and the 5x5 odd lane
`timescale 1ns/100ps

module conv_sum_sva (
    input logic                       clk,
    input logic                       rst,
    input conv_sum_pkg::window_req_t  i_window,
    input conv_sum_pkg::kernel_sum_t  i_kernel_sum,
    input conv_sum_pkg::conv_result_t i_result
);
    import conv_sum_pkg::*;

    localparam int PIPE_LATENCY = TREE_LATENCY + POST_LATENCY;

    // cycles since reset release, saturates once the pipeline has refilled
    logic [3:0] settle_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            settle_cnt <= '0;
        end else if (settle_cnt < 4'(PIPE_LATENCY)) begin
            settle_cnt <= settle_cnt + 4'd1;
        end
    end

    reset_clears_valid: assert property (@(posedge clk) rst |=> !i_result.valid)
        else $error("result valid high in the cycle after reset");

    // nothing can surface before the first window has crossed the pipeline
    quiet_after_reset: assert property (@(posedge clk) disable iff (rst)
        settle_cnt < 4'(PIPE_LATENCY) |-> !i_result.valid)
        else $error("result valid high before the pipeline could refill");

    valid_follows_window: assert property (@(posedge clk) disable iff (rst)
        settle_cnt == 4'(PIPE_LATENCY) |-> i_result.valid == $past(i_window.valid, PIPE_LATENCY))
        else $error("result valid does not match window valid six cycles earlier");

    // odd lane zero once a 5x5 sum has passed scale and bias
    odd_zero_in_5x5: assert property (@(posedge clk) disable iff (rst)
        (i_kernel_sum.valid && i_kernel_sum.mode == KN_MODE_5X5)
        |-> ##POST_LATENCY (i_result.result_odd == '0))
        else $error("result_odd not zero for a 5x5 window");

endmodule

/* verification/conv_sum_tb.sv */
// clock, reset, LFSR stimulus, reference model, scoreboard and final report for the summing unit
`timescale 1ns/100ps

module conv_sum_tb;
    import conv_sum_pkg::*;

    localparam int CLK_PERIOD    = 40;
    localparam int DRIVE_DELAY   = 5;
    localparam int RESET_CYCLES  = 5;
    localparam int PIPE_LATENCY  = TREE_LATENCY + POST_LATENCY;
    localparam int DRAIN_TIMEOUT = 40;

    logic         clk;
    logic         rst;
    window_req_t  window;
    post_params_t post;
    conv_result_t result;

    logic [31:0]  lfsr_state;
    conv_result_t expected_q[$];
    int           sent_count;
    int           result_count;
    int           mismatch_count;
    int           unexpected_count;
    int           other_error_count;

    conv_sum_top UUT (
        .clk      (clk),
        .rst      (rst),
        .i_window (window),
        .i_post   (post),
        .o_result (result)
    );

    bind conv_sum_top conv_sum_sva u_sva (
        .clk          (clk),
        .rst          (rst),
        .i_window     (i_window),
        .i_kernel_sum (kernel_sum),
        .i_result     (o_result)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1 LFSR stepped once per bit
    function automatic logic [31:0] random_bits(input int nbits);
        logic [31:0] value;
        logic        feedback;
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], feedback};
            value      = {value[30:0], feedback};
        end
        return value;
    endfunction

    function automatic logic random_bit();
        logic [31:0] value;
        value = random_bits(1);
        return value[0];
    endfunction

    function automatic window_req_t random_window(input kernel_mode_e mode,
                                                  input feature_t tap_floor);
        window_req_t w;
        w.valid   = 1'b1;
        w.mode    = mode;
        w.channel = CHANNEL_WIDTH'(random_bits(CHANNEL_WIDTH));
        for (int t = 0; t < WINDOW_TAPS; t++) begin
            w.taps[t] = tap_floor | FEATURE_WIDTH'(random_bits(FEATURE_WIDTH));
        end
        return w;
    endfunction

    // expected output with sums and products wrapping at 16 bits
    function automatic conv_result_t model_result(input window_req_t w, input post_params_t p);
        feature_t     sum_even;
        feature_t     sum_odd;
        conv_result_t r;
        sum_even = '0;
        sum_odd  = '0;
        if (w.mode == KN_MODE_5X5) begin
            for (int t = 0; t < WINDOW_TAPS; t++) begin
                sum_even += w.taps[t];
            end
        end else begin
            for (int t = 0; t < KERNEL3_TAPS; t++) begin
                sum_even += w.taps[t];
                sum_odd  += w.taps[t + KERNEL3_TAPS];
            end
        end
        r.valid       = 1'b1;
        r.channel     = w.channel;
        r.result_even = sum_even * p.scaler + p.bias;
        r.result_odd  = (w.mode == KN_MODE_3X3) ? sum_odd * p.scaler + p.bias : '0;
        return r;
    endfunction

    task automatic next_drive_slot();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic drive_window(input window_req_t w);
        next_drive_slot();
        window = w;
        expected_q.push_back(model_result(w, post));
        sent_count++;
    endtask

    task automatic wait_drain();
        int cycles;
        next_drive_slot();
        window = '0;
        cycles = 0;
        while (expected_q.size() != 0 && cycles < DRAIN_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        assert (expected_q.size() == 0) else begin
            other_error_count++;
            $display("%0t: pipeline did not drain, %0d results still missing",
                     $time, expected_q.size());
        end
    endtask

    task automatic set_post(input logic [SCALER_WIDTH-1:0] scaler, input feature_t bias);
        next_drive_slot();
        post.scaler = scaler;
        post.bias   = bias;
    endtask

    task automatic run_burst(input int count, input bit mixed, input kernel_mode_e mode,
                             input feature_t tap_floor);
        kernel_mode_e m;
        for (int n = 0; n < count; n++) begin
            m = mixed ? kernel_mode_e'(random_bit()) : mode;
            drive_window(random_window(m, tap_floor));
        end
        wait_drain();
    endtask

    // same 3x3 window twice with only the unused taps 18..24 changed
    task automatic send_tail_variants(input int pairs);
        window_req_t w;
        for (int p = 0; p < pairs; p++) begin
            w = random_window(KN_MODE_3X3, '0);
            drive_window(w);
            for (int t = 2 * KERNEL3_TAPS; t < WINDOW_TAPS; t++) begin
                w.taps[t] = FEATURE_WIDTH'(random_bits(FEATURE_WIDTH));
            end
            drive_window(w);
        end
        wait_drain();
    endtask

    // garbage on the inputs while rst is high and a quiet pipeline afterwards
    task automatic apply_reset();
        rst = 1'b1;
        for (int c = 0; c < RESET_CYCLES; c++) begin
            window = random_window(kernel_mode_e'(random_bit()), '0);
            @(negedge clk);
            assert (!result.valid) else begin
                other_error_count++;
                $display("%0t: result valid went high during reset", $time);
            end
            next_drive_slot();
        end
        rst    = 1'b0;
        window = '0;
        for (int c = 0; c < PIPE_LATENCY; c++) begin
            @(negedge clk);
            assert (!result.valid) else begin
                other_error_count++;
                $display("%0t: result valid went high right after reset", $time);
            end
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin : scoreboard
        conv_result_t exp_r;
        if (!rst && result.valid) begin
            assert (expected_q.size() != 0) else begin
                unexpected_count++;
                $display("%0t: result on channel %0d arrived with no window outstanding",
                         $time, result.channel);
            end
            if (expected_q.size() != 0) begin
                exp_r = expected_q.pop_front();
                result_count++;
                assert (result.channel == exp_r.channel) else begin
                    mismatch_count++;
                    $display("MISMATCH %0t: channel got %0d expected %0d",
                             $time, result.channel, exp_r.channel);
                end
                assert (result.result_even == exp_r.result_even) else begin
                    mismatch_count++;
                    $display("MISMATCH %0t: result_even got %h expected %h",
                             $time, result.result_even, exp_r.result_even);
                end
                assert (result.result_odd == exp_r.result_odd) else begin
                    mismatch_count++;
                    $display("MISMATCH %0t: result_odd got %h expected %h",
                             $time, result.result_odd, exp_r.result_odd);
                end
            end
        end
    end

    initial begin
        $timeformat(-9, 1, " ns", 0);
        clk               = 1'b0;
        rst               = 1'b1;
        window            = '0;
        post              = '0;
        lfsr_state        = 32'h2abe52b4;
        sent_count        = 0;
        result_count      = 0;
        mismatch_count    = 0;
        unexpected_count  = 0;
        other_error_count = 0;
        apply_reset();

        set_post(16'd3, 16'd7);
        run_burst(10, 1'b0, KN_MODE_5X5, '0);
        run_burst(10, 1'b0, KN_MODE_3X3, '0);
        send_tail_variants(4);
        // mixed modes on every cycle
        run_burst(40, 1'b1, KN_MODE_5X5, '0);
        // near-max taps and scaler force wraparound
        set_post(16'hfff1, 16'hff37);
        run_burst(20, 1'b1, KN_MODE_5X5, 16'hff00);
        for (int b = 0; b < 3; b++) begin
            set_post(SCALER_WIDTH'(random_bits(SCALER_WIDTH)),
                     FEATURE_WIDTH'(random_bits(FEATURE_WIDTH)));
            run_burst(12, 1'b1, KN_MODE_5X5, '0);
        end
        next_drive_slot();
        apply_reset();
        run_burst(8, 1'b1, KN_MODE_5X5, '0);

        assert (expected_q.size() == 0 && result_count == sent_count) else begin
            other_error_count++;
            $display("%0t: %0d windows sent but %0d results received",
                     $time, sent_count, result_count);
        end
        $display("errors: %0d mismatches, %0d unexpected results, %0d other (%0d results)",
                 mismatch_count, unexpected_count, other_error_count, result_count);
        if (mismatch_count == 0 && unexpected_count == 0 && other_error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* conv_sum.f */
logic/conv_sum_pkg.sv
logic/kernel_adder_tree.sv
logic/kernel_sum_stage.sv
logic/scale_bias_stage.sv
logic/conv_sum_top.sv
verification/conv_sum_sva.sv
verification/conv_sum_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := conv_sum_tb
FILELIST  := conv_sum.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := TEST FAILED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
